// ==== common/cp0_pkg.sv ====
package cp0_pkg;

	// register numbers, select 0 unless noted
	localparam logic [4:0] reg_random   = 5'd1;
	localparam logic [4:0] reg_wired    = 5'd6;
	localparam logic [4:0] reg_badvaddr = 5'd8;
	localparam logic [4:0] reg_count    = 5'd9;
	localparam logic [4:0] reg_compare  = 5'd11;
	localparam logic [4:0] reg_status   = 5'd12;
	localparam logic [4:0] reg_cause    = 5'd13;
	localparam logic [4:0] reg_epc      = 5'd14;
	localparam logic [4:0] reg_prid     = 5'd15; // EBase sits at select 1
	localparam logic [4:0] reg_config   = 5'd16;

	// Status fields
	localparam int status_ie_bit  = 0;
	localparam int status_exl_bit = 1;
	localparam int status_im_lsb  = 8;  // IM7..IM0
	localparam int status_bev_bit = 22;

	// Cause fields
	localparam int cause_exc_lsb = 2;  // 5-bit ExcCode
	localparam int cause_ip_lsb  = 8;  // IP7..IP0
	localparam int cause_ti_bit  = 30;
	localparam int cause_bd_bit  = 31;

	localparam logic [31:0] status_reset = 32'h0040_0000; // BEV set
	localparam logic [31:0] config_reset = 32'h0000_8000;
	localparam logic [31:0] prid_value   = 32'h0001_8003;
	localparam logic [31:0] ebase_reset  = 32'h8000_0000;

	// Random/Wired only index the TLB
	localparam int tlb_line_num = 16;
	localparam int tlb_idx_w    = $clog2(tlb_line_num);
	localparam logic [tlb_idx_w-1:0] random_max = tlb_idx_w'(tlb_line_num - 1);

endpackage

// ==== common/exc_pkg.sv ====
package exc_pkg;

	// ExcCode values as written to Cause
	typedef enum logic [4:0] {
		exc_int  = 5'd0,
		exc_adel = 5'd4,
		exc_ades = 5'd5,
		exc_sys  = 5'd8,
		exc_bp   = 5'd9,
		exc_ri   = 5'd10,
		exc_ov   = 5'd12,
		exc_tr   = 5'd13
	} exc_code_e;

	// memory access of the retiring instruction
	typedef enum logic [2:0] {
		mem_none = 3'd0,
		mem_lb   = 3'd1,
		mem_lh   = 3'd2,
		mem_lw   = 3'd3,
		mem_sb   = 3'd4,
		mem_sh   = 3'd5,
		mem_sw   = 3'd6
	} mem_op_e;

	localparam logic [31:0] vec_offset  = 32'h0000_0180; // general exception offset
	localparam logic [31:0] boot_vector = 32'hbfc0_0380; // used while BEV=1

endpackage

// ==== cp0/cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic [5:0]            int_i,
	input  logic                  cp0_we_i,
	input  logic [4:0]            cp0_waddr_i,
	input  logic [2:0]            cp0_wsel_i,
	input  logic [31:0]           cp0_wdata_i,
	input  logic [4:0]            cp0_raddr_i,
	input  logic [2:0]            cp0_rsel_i,
	output logic [31:0]           cp0_rdata_o,
	input  logic                  commit_i,
	input  logic                  exc_taken_i,
	input  exc_pkg::exc_code_e    exc_code_i,
	input  logic                  exc_eret_i,
	input  logic [31:0]           rec_pc_i,
	input  logic                  rec_delay_slot_i,
	input  logic [31:0]           rec_bad_addr_i,
	output logic [31:0]           status_o,
	output logic [31:0]           cause_o,
	output logic [31:0]           epc_o,
	output logic [31:0]           ebase_o
);

	logic [32:0]                   count_q; // Count is the upper 32 bits
	logic [31:0]                   count;
	logic [31:0]                   compare_q;
	logic [31:0]                   badvaddr_q;
	logic [cp0_pkg::tlb_idx_w-1:0] random_q;
	logic [cp0_pkg::tlb_idx_w-1:0] wired_q;
	logic                          exc_wr;
	logic                          eret_wr;
	logic                          addr_err;

	assign count    = count_q[32:1];
	assign exc_wr   = commit_i & exc_taken_i;
	assign eret_wr  = commit_i & exc_eret_i;
	assign addr_err = (exc_code_i == exc_pkg::exc_adel) | (exc_code_i == exc_pkg::exc_ades);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count_q   <= '0;
			compare_q <= '0;
			status_o  <= cp0_pkg::status_reset;
			cause_o   <= '0;
			epc_o     <= '0;
			ebase_o   <= cp0_pkg::ebase_reset;
			random_q  <= cp0_pkg::random_max;
			wired_q   <= '0;
		end else begin
			count_q <= count_q + 33'd1;
			if (random_q == wired_q) begin
				random_q <= cp0_pkg::random_max;
			end else begin
				random_q <= random_q - 1'b1;
			end
			cause_o[cp0_pkg::cause_ip_lsb+2 +: 6] <= int_i; // IP7..IP2
			if (compare_q != '0 && count == compare_q) begin
				cause_o[cp0_pkg::cause_ti_bit] <= 1'b1;
			end

			if (cp0_we_i) begin
				case (cp0_waddr_i)
					cp0_pkg::reg_count:   count_q <= {cp0_wdata_i, 1'b0};
					cp0_pkg::reg_compare: begin
						compare_q                      <= cp0_wdata_i;
						cause_o[cp0_pkg::cause_ti_bit] <= 1'b0; // ack timer
					end
					cp0_pkg::reg_status:  status_o <= cp0_wdata_i;
					cp0_pkg::reg_cause: begin
						cause_o[cp0_pkg::cause_ip_lsb +: 2] <= cp0_wdata_i[cp0_pkg::cause_ip_lsb +: 2];
					end
					cp0_pkg::reg_epc:     epc_o <= cp0_wdata_i;
					cp0_pkg::reg_wired: begin
						wired_q  <= cp0_wdata_i[cp0_pkg::tlb_idx_w-1:0];
						random_q <= cp0_pkg::random_max;
					end
					cp0_pkg::reg_prid: begin
						if (cp0_wsel_i == 3'd1) begin
							ebase_o[29:0] <= cp0_wdata_i[29:0];
						end
					end
					default: ;
				endcase
			end

			// commit overrides a software write to the same field
			if (exc_wr) begin
				epc_o                               <= rec_delay_slot_i ? rec_pc_i - 32'd4 : rec_pc_i;
				cause_o[cp0_pkg::cause_bd_bit]      <= rec_delay_slot_i;
				cause_o[cp0_pkg::cause_exc_lsb +: 5] <= exc_code_i;
				status_o[cp0_pkg::status_exl_bit]   <= 1'b1;
			end else if (eret_wr) begin
				status_o[cp0_pkg::status_exl_bit] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (exc_wr && addr_err) begin
			badvaddr_q <= rec_bad_addr_i;
		end
	end

	always_comb begin
		case (cp0_raddr_i)
			cp0_pkg::reg_count:    cp0_rdata_o = count;
			cp0_pkg::reg_compare:  cp0_rdata_o = compare_q;
			cp0_pkg::reg_status:   cp0_rdata_o = status_o;
			cp0_pkg::reg_cause:    cp0_rdata_o = cause_o;
			cp0_pkg::reg_epc:      cp0_rdata_o = epc_o;
			cp0_pkg::reg_badvaddr: cp0_rdata_o = badvaddr_q;
			cp0_pkg::reg_config:   cp0_rdata_o = cp0_pkg::config_reset;
			cp0_pkg::reg_random:   cp0_rdata_o = {{(32 - cp0_pkg::tlb_idx_w){1'b0}}, random_q};
			cp0_pkg::reg_wired:    cp0_rdata_o = {{(32 - cp0_pkg::tlb_idx_w){1'b0}}, wired_q};
			cp0_pkg::reg_prid:     cp0_rdata_o = (cp0_rsel_i == 3'd1) ? ebase_o : cp0_pkg::prid_value;
			default:               cp0_rdata_o = '0;
		endcase
	end

endmodule

// ==== cp0/exc_prioritize.sv ====
`timescale 1ns/1ps

module exc_prioritize (
	input  logic                  rec_valid_i,
	input  logic                  rec_adel_i,
	input  logic                  rec_ades_i,
	input  logic                  rec_ri_i,
	input  logic                  rec_sys_i,
	input  logic                  rec_bp_i,
	input  logic                  rec_ov_i,
	input  logic                  rec_trap_i,
	input  logic                  rec_eret_i,
	input  logic [31:0]           status_i,
	input  logic [31:0]           cause_i,
	output logic                  exc_taken_o,
	output exc_pkg::exc_code_e    exc_code_o,
	output logic                  exc_eret_o
);

	logic int_pend;
	logic any_exc;
	logic ip_hit;

	assign ip_hit = |(status_i[cp0_pkg::status_im_lsb +: 8] & cause_i[cp0_pkg::cause_ip_lsb +: 8]);

	// masked off at exception level
	assign int_pend = status_i[cp0_pkg::status_ie_bit] & ~status_i[cp0_pkg::status_exl_bit] &
		(ip_hit | cause_i[cp0_pkg::cause_ti_bit]);

	always_comb begin
		any_exc    = 1'b1;
		exc_code_o = exc_pkg::exc_int;
		if (int_pend) begin
			exc_code_o = exc_pkg::exc_int;
		end else if (rec_adel_i) begin
			exc_code_o = exc_pkg::exc_adel;
		end else if (rec_ri_i) begin
			exc_code_o = exc_pkg::exc_ri;
		end else if (rec_sys_i) begin
			exc_code_o = exc_pkg::exc_sys;
		end else if (rec_bp_i) begin
			exc_code_o = exc_pkg::exc_bp;
		end else if (rec_ades_i) begin
			exc_code_o = exc_pkg::exc_ades;
		end else if (rec_ov_i) begin
			exc_code_o = exc_pkg::exc_ov;
		end else if (rec_trap_i) begin
			exc_code_o = exc_pkg::exc_tr;
		end else begin
			any_exc = 1'b0;
		end
	end

	assign exc_taken_o = rec_valid_i & any_exc;
	assign exc_eret_o  = rec_valid_i & rec_eret_i & ~any_exc; // eret loses to any cause

endmodule

// ==== dv/exc_checker.sv ====
`timescale 1ns/1ps

module exc_checker (
	input logic        clk,
	input logic        rst_n_i,
	input logic        redirect_valid_i,
	input logic        redirect_ready_i,
	input logic [31:0] redirect_pc_i,
	input logic [4:0]  redirect_code_i,
	input logic        redirect_eret_i
);

	int          err_count;
	int          check_count;
	logic [31:0] exp_pc[$];
	logic [4:0]  exp_code[$];
	logic        exp_eret[$];

	initial begin
		err_count   = 0;
		check_count = 0;
	end

	task automatic expect_redirect(input logic [31:0] pc, input logic [4:0] code,
		input logic eret);
		exp_pc.push_back(pc);
		exp_code.push_back(code);
		exp_eret.push_back(eret);
	endtask

	function automatic int expected_left();
		return exp_pc.size();
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		check_count++;
		err_count++;
		$display("failure: %s", what);
	endtask

	// one redirect per accepted transfer, in model order
	always @(posedge clk) begin
		if (rst_n_i && redirect_valid_i && redirect_ready_i) begin
			if (exp_pc.size() == 0) begin
				report_failure("a redirect arrived while none was expected");
			end else begin
				check_value("redirect_pc_o", redirect_pc_i, exp_pc.pop_front());
				check_value("redirect_code_o", {27'd0, redirect_code_i},
					{27'd0, exp_code.pop_front()});
				check_value("redirect_eret_o", {31'd0, redirect_eret_i},
					{31'd0, exp_eret.pop_front()});
			end
		end
	end

endmodule

// ==== dv/exc_unit_tb.sv ====
`timescale 1ns/1ps

module exc_unit_tb;

	localparam int num_tests   = 6;
	localparam int max_records = 100;
	localparam longint watchdog_ns = num_tests * max_records * 20 * 10;

	logic               clk;
	logic               rst_n_i;
	logic               in_valid_i;
	logic               in_ready_o;
	logic [31:0]        in_pc_i;
	logic               in_delay_slot_i;
	exc_pkg::mem_op_e   in_mem_op_i;
	logic [31:0]        in_mem_addr_i;
	logic               in_ri_i;
	logic               in_sys_i;
	logic               in_bp_i;
	logic               in_ov_i;
	logic               in_trap_i;
	logic               in_eret_i;
	logic [5:0]         int_i;
	logic               cp0_we_i;
	logic [4:0]         cp0_waddr_i;
	logic [2:0]         cp0_wsel_i;
	logic [31:0]        cp0_wdata_i;
	logic [4:0]         cp0_raddr_i;
	logic [2:0]         cp0_rsel_i;
	logic [31:0]        cp0_rdata_o;
	logic               redirect_valid_o;
	logic               redirect_ready_i;
	logic [31:0]        redirect_pc_o;
	exc_pkg::exc_code_e redirect_code_o;
	logic               redirect_eret_o;

	logic [31:0] seed;
	logic        bp_on;
	// model state
	logic [31:0] m_status;
	logic [31:0] m_epc;
	logic [31:0] m_ebase;
	logic [31:0] m_badv;
	logic        m_badv_set;
	logic        m_bd;
	logic [4:0]  m_exc;
	logic [1:0]  m_swip;
	logic        m_ti;

	exc_unit i_exc_unit (.*);

	exc_checker i_exc_checker (
		.clk, .rst_n_i, .redirect_valid_i(redirect_valid_o), .redirect_ready_i,
		.redirect_pc_i(redirect_pc_o), .redirect_code_i(redirect_code_o),
		.redirect_eret_i(redirect_eret_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: the tests did not finish in the expected time");
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic drive_ready();
		logic [31:0] r;
		r = lcg_next();
		redirect_ready_i = bp_on ? (r[19:16] > 4'd5) : 1'b1;
	endtask

	task automatic read_cp0(input logic [4:0] addr, input logic [2:0] sel,
		output logic [31:0] data);
		cp0_raddr_i = addr;
		cp0_rsel_i  = sel;
		#1;
		data = cp0_rdata_o;
	endtask

	task automatic write_cp0(input logic [4:0] addr, input logic [2:0] sel,
		input logic [31:0] data);
		cp0_we_i    = 1'b1;
		cp0_waddr_i = addr;
		cp0_wsel_i  = sel;
		cp0_wdata_i = data;
		@(negedge clk);
		cp0_we_i = 1'b0;
		case (addr)
			5'd12: m_status = data;
			5'd14: m_epc = data;
			5'd13: m_swip = data[9:8];
			5'd11: m_ti = 1'b0;
			5'd15: if (sel == 3'd1) m_ebase[29:0] = data[29:0];
			default: ;
		endcase
	endtask

	// expected effect of one record, applied in commit order
	task automatic model_record(input logic [31:0] pc, input logic dslot,
		input logic [2:0] op, input logic [31:0] addr, input logic [5:0] flags);
		logic       adel;
		logic       ades;
		logic       pend;
		logic       taken;
		logic [4:0] code;
		adel = (|pc[1:0]) || (op == 3'd3 && |addr[1:0]) || (op == 3'd2 && addr[0]);
		ades = (op == 3'd6 && |addr[1:0]) || (op == 3'd5 && addr[0]);
		pend = m_status[0] & ~m_status[1] & ((|(m_status[15:8] & {6'd0, m_swip})) | m_ti);
		taken = 1'b1;
		code  = 5'd0;
		if (pend) code = 5'd0;
		else if (adel) code = 5'd4;
		else if (flags[5]) code = 5'd10;
		else if (flags[4]) code = 5'd8;
		else if (flags[3]) code = 5'd9;
		else if (ades) code = 5'd5;
		else if (flags[2]) code = 5'd12;
		else if (flags[1]) code = 5'd13;
		else taken = 1'b0;
		if (taken) begin
			i_exc_checker.expect_redirect(m_status[22] ? 32'hbfc0_0380 : m_ebase + 32'h180,
				code, 1'b0);
			m_epc       = dslot ? pc - 32'd4 : pc;
			m_bd        = dslot;
			m_exc       = code;
			m_status[1] = 1'b1;
			if (code == 5'd4 || code == 5'd5) begin
				m_badv     = (|pc[1:0]) ? pc : addr;
				m_badv_set = 1'b1;
			end
		end else if (flags[0]) begin
			i_exc_checker.expect_redirect(m_epc, 5'd0, 1'b1);
			m_status[1] = 1'b0;
		end
	endtask

	task automatic send_record(input logic [31:0] pc, input logic dslot,
		input logic [2:0] op, input logic [31:0] addr, input logic [5:0] flags);
		int waited;
		waited = 0;
		drive_ready();
		in_valid_i      = 1'b1;
		in_pc_i         = pc;
		in_delay_slot_i = dslot;
		in_mem_op_i     = exc_pkg::mem_op_e'(op);
		in_mem_addr_i   = addr;
		{in_ri_i, in_sys_i, in_bp_i, in_ov_i, in_trap_i, in_eret_i} = flags;
		#1; // in_ready_o follows redirect_ready_i
		while (!in_ready_o && waited < 200) begin
			@(negedge clk);
			drive_ready();
			#1;
			waited++;
		end
		if (!in_ready_o) i_exc_checker.report_failure("in_ready_o stayed low, record not taken");
		model_record(pc, dslot, op, addr, flags);
		@(negedge clk);
		in_valid_i = 1'b0;
		drive_ready();
	endtask

	task automatic random_record();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [5:0]  flags;
		r1 = lcg_next();
		r2 = lcg_next();
		flags = {r2[2:0] == 0, r2[5:3] == 0, r2[8:6] == 0, r2[11:9] == 0,
			r2[14:12] == 0, r2[17:15] == 0};
		send_record({r1[31:2], (r1[30:28] == 0) ? r1[1:0] : 2'b00}, r2[21],
			3'(r2[27:25] % 3'd7), lcg_next(), flags);
	endtask

	task automatic drain();
		int stable;
		int cycles;
		stable = 0;
		cycles = 0;
		while (stable < 3 && cycles < 100) begin
			@(negedge clk);
			redirect_ready_i = 1'b1;
			if (in_ready_o && !redirect_valid_o && i_exc_checker.expected_left() == 0) stable++;
			else stable = 0;
			cycles++;
		end
		if (stable < 3) i_exc_checker.report_failure("expected redirects never arrived");
	endtask

	task automatic check_cp0_state();
		logic [31:0] d;
		read_cp0(5'd14, 3'd0, d);
		i_exc_checker.check_value("epc", d, m_epc);
		read_cp0(5'd13, 3'd0, d);
		i_exc_checker.check_value("cause", d,
			{m_bd, m_ti, 20'd0, m_swip, 1'b0, m_exc, 2'b00});
		read_cp0(5'd12, 3'd0, d);
		i_exc_checker.check_value("status", d, m_status);
		if (m_badv_set) begin
			read_cp0(5'd8, 3'd0, d);
			i_exc_checker.check_value("badvaddr", d, m_badv);
		end
	endtask

	task automatic test_done(input int num, input string name);
		$display("test %0d %s done, errors so far %0d", num, name, i_exc_checker.err_count);
	endtask

	initial begin
		logic [31:0] d;
		logic [31:0] prev;
		int          waited;
		seed = 32'h79eb_da27;
		bp_on = 1'b0;
		m_status = 32'h0040_0000;
		m_epc = '0;
		m_ebase = 32'h8000_0000;
		m_badv = '0;
		m_badv_set = 1'b0;
		m_bd = 1'b0;
		m_exc = '0;
		m_swip = '0;
		m_ti = 1'b0;
		rst_n_i = 1'b0;
		in_valid_i = 1'b0;
		in_pc_i = '0;
		in_delay_slot_i = 1'b0;
		in_mem_op_i = exc_pkg::mem_none;
		in_mem_addr_i = '0;
		{in_ri_i, in_sys_i, in_bp_i, in_ov_i, in_trap_i, in_eret_i} = '0;
		int_i = '0;
		cp0_we_i = 1'b0;
		cp0_waddr_i = '0;
		cp0_wsel_i = '0;
		cp0_wdata_i = '0;
		cp0_raddr_i = '0;
		cp0_rsel_i = '0;
		redirect_ready_i = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;

		read_cp0(5'd1, 3'd0, d);
		i_exc_checker.check_value("random", d, 32'd15);
		read_cp0(5'd12, 3'd0, d);
		i_exc_checker.check_value("status", d, 32'h0040_0000);
		read_cp0(5'd16, 3'd0, d);
		i_exc_checker.check_value("config", d, 32'h0000_8000);
		read_cp0(5'd15, 3'd0, d);
		i_exc_checker.check_value("prid", d, 32'h0001_8003);
		read_cp0(5'd15, 3'd1, d);
		i_exc_checker.check_value("ebase", d, 32'h8000_0000);
		i_exc_checker.check_value("in_ready_o", {31'd0, in_ready_o}, 32'd1);
		i_exc_checker.check_value("redirect_valid_o", {31'd0, redirect_valid_o}, 32'd0);
		test_done(1, "reset values");

		for (int round = 0; round < 4; round++) begin
			d = lcg_next();
			write_cp0(5'd12, 3'd0, d[0] ? 32'h0040_0000 : 32'h0);
			write_cp0(5'd15, 3'd1, {2'b10, d[29:12], 12'h000});
			for (int i = 0; i < 10; i++) random_record();
			drain();
			check_cp0_state();
		end
		test_done(2, "random records");

		write_cp0(5'd14, 3'd0, 32'h8000_2040);
		write_cp0(5'd12, 3'd0, 32'h0000_0002); // EXL set
		send_record(32'h8000_3000, 1'b0, 3'd0, 32'h0, 6'b000001);
		drain();
		check_cp0_state();
		test_done(3, "eret");

		write_cp0(5'd12, 3'd0, 32'h0000_0101); // IE and IM0
		write_cp0(5'd13, 3'd0, 32'h0000_0100); // software IP0
		send_record(32'h8000_4000, 1'b1, 3'd0, 32'h0, 6'b0);
		send_record(32'h8000_4010, 1'b0, 3'd0, 32'h0, 6'b0); // EXL blocks
		drain();
		check_cp0_state();
		write_cp0(5'd13, 3'd0, 32'h0);
		send_record(32'h8000_4020, 1'b0, 3'd0, 32'h0, 6'b000001);
		drain();
		read_cp0(5'd9, 3'd0, d);
		write_cp0(5'd11, 3'd0, d + 32'd10);
		waited = 0;
		read_cp0(5'd13, 3'd0, d);
		while (!d[30] && waited < 200) begin
			@(negedge clk);
			read_cp0(5'd13, 3'd0, d);
			waited++;
		end
		if (!d[30]) i_exc_checker.report_failure("timer interrupt bit never set");
		m_ti = 1'b1;
		@(negedge clk);
		send_record(32'h8000_5000, 1'b0, 3'd0, 32'h0, 6'b0);
		drain();
		check_cp0_state();
		write_cp0(5'd11, 3'd0, 32'h0);
		write_cp0(5'd12, 3'd0, 32'h0);
		test_done(4, "interrupts");

		bp_on = 1'b1;
		for (int i = 0; i < 60; i++) random_record();
		bp_on = 1'b0;
		drain();
		check_cp0_state();
		test_done(5, "back-pressure");

		@(negedge clk);
		read_cp0(5'd1, 3'd0, prev);
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			read_cp0(5'd1, 3'd0, d);
			// Wired is still 0 here
			i_exc_checker.check_value("random", d, (prev == 32'd0) ? 32'd15 : prev - 32'd1);
			prev = d;
		end
		write_cp0(5'd6, 3'd0, 32'd5);
		read_cp0(5'd1, 3'd0, d);
		i_exc_checker.check_value("random", d, 32'd15);
		for (int i = 0; i < 30; i++) begin
			@(negedge clk);
			read_cp0(5'd1, 3'd0, d);
			if (d < 32'd5 || d > 32'd15) i_exc_checker.report_failure("random left the wired range");
		end
		write_cp0(5'd6, 3'd0, 32'd0);
		write_cp0(5'd9, 3'd0, 32'h0000_0100);
		read_cp0(5'd9, 3'd0, prev);
		for (int i = 0; i < 20; i++) begin
			d = lcg_next();
			repeat (1 + d[2:0]) @(negedge clk);
			read_cp0(5'd9, 3'd0, d);
			if (d < prev) i_exc_checker.report_failure("count went backwards");
			prev = d;
		end
		repeat (100) @(negedge clk);
		read_cp0(5'd9, 3'd0, d);
		if (d - prev < 32'd49 || d - prev > 32'd51)
			i_exc_checker.report_failure("count did not advance at half the clock rate");
		test_done(6, "counters");

		$display("checks %0d, errors %0d", i_exc_checker.check_count, i_exc_checker.err_count);
		if (i_exc_checker.err_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== project.f ====
common/cp0_pkg.sv
common/exc_pkg.sv
src/exc_collect.sv
cp0/exc_prioritize.sv
cp0/cp0_regs.sv
src/redirect_gen.sv
src/exc_unit.sv
dv/exc_checker.sv
dv/exc_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the exc_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f --top-module exc_unit_tb -o exc_unit_sim
./obj_dir/exc_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
grep -q "NO ERRORS" sim.log

// ==== src/exc_collect.sv ====
`timescale 1ns/1ps

module exc_collect (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                in_valid_i,
	output logic                in_ready_o,
	input  logic [31:0]         in_pc_i,
	input  logic                in_delay_slot_i,
	input  exc_pkg::mem_op_e    in_mem_op_i,
	input  logic [31:0]         in_mem_addr_i,
	input  logic                in_ri_i,
	input  logic                in_sys_i,
	input  logic                in_bp_i,
	input  logic                in_ov_i,
	input  logic                in_trap_i,
	input  logic                in_eret_i,
	input  logic                commit_i,
	output logic                rec_valid_o,
	output logic [31:0]         rec_pc_o,
	output logic                rec_delay_slot_o,
	output logic [31:0]         rec_bad_addr_o,
	output logic                rec_adel_o,
	output logic                rec_ades_o,
	output logic                rec_ri_o,
	output logic                rec_sys_o,
	output logic                rec_bp_o,
	output logic                rec_ov_o,
	output logic                rec_trap_o,
	output logic                rec_eret_o
);

	logic       accept;
	logic       pc_err;
	logic       load_err;
	logic       store_err;
	logic [5:0] flags_q; // ri, sys, bp, ov, trap, eret

	assign in_ready_o = ~rec_valid_o | commit_i; // slot frees on commit
	assign accept     = in_valid_i & in_ready_o;
	assign pc_err     = |in_pc_i[1:0];

	always_comb begin
		load_err  = 1'b0;
		store_err = 1'b0;
		case (in_mem_op_i)
			exc_pkg::mem_lw: load_err  = |in_mem_addr_i[1:0];
			exc_pkg::mem_lh: load_err  = in_mem_addr_i[0];
			exc_pkg::mem_sw: store_err = |in_mem_addr_i[1:0];
			exc_pkg::mem_sh: store_err = in_mem_addr_i[0];
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rec_valid_o <= 1'b0;
		end else if (accept) begin
			rec_valid_o <= 1'b1;
		end else if (commit_i) begin
			rec_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rec_pc_o         <= in_pc_i;
			rec_delay_slot_o <= in_delay_slot_i;
			rec_bad_addr_o   <= pc_err ? in_pc_i : in_mem_addr_i; // fetch error first
			rec_adel_o       <= pc_err | load_err;
			rec_ades_o       <= store_err;
			flags_q          <= {in_ri_i, in_sys_i, in_bp_i, in_ov_i, in_trap_i, in_eret_i};
		end
	end

	assign {rec_ri_o, rec_sys_o, rec_bp_o, rec_ov_o, rec_trap_o, rec_eret_o} = flags_q;

endmodule

// ==== src/exc_unit.sv ====
`timescale 1ns/1ps

module exc_unit (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  in_valid_i,
	output logic                  in_ready_o,
	input  logic [31:0]           in_pc_i,
	input  logic                  in_delay_slot_i,
	input  exc_pkg::mem_op_e      in_mem_op_i,
	input  logic [31:0]           in_mem_addr_i,
	input  logic                  in_ri_i,
	input  logic                  in_sys_i,
	input  logic                  in_bp_i,
	input  logic                  in_ov_i,
	input  logic                  in_trap_i,
	input  logic                  in_eret_i,
	input  logic [5:0]            int_i,
	input  logic                  cp0_we_i,
	input  logic [4:0]            cp0_waddr_i,
	input  logic [2:0]            cp0_wsel_i,
	input  logic [31:0]           cp0_wdata_i,
	input  logic [4:0]            cp0_raddr_i,
	input  logic [2:0]            cp0_rsel_i,
	output logic [31:0]           cp0_rdata_o,
	output logic                  redirect_valid_o,
	input  logic                  redirect_ready_i,
	output logic [31:0]           redirect_pc_o,
	output exc_pkg::exc_code_e    redirect_code_o,
	output logic                  redirect_eret_o
);

	logic               redir_free; // doubles as commit, blocks gate with their own valid
	logic               rec_valid;
	logic [31:0]        rec_pc;
	logic               rec_delay_slot;
	logic [31:0]        rec_bad_addr;
	logic               rec_adel;
	logic               rec_ades;
	logic               rec_ri;
	logic               rec_sys;
	logic               rec_bp;
	logic               rec_ov;
	logic               rec_trap;
	logic               rec_eret;
	logic               exc_taken;
	exc_pkg::exc_code_e exc_code;
	logic               exc_eret;
	logic [31:0]        status;
	logic [31:0]        cause;
	logic [31:0]        epc;
	logic [31:0]        ebase;

	exc_collect i_exc_collect (
		.clk, .rst_n_i, .in_valid_i, .in_ready_o, .in_pc_i, .in_delay_slot_i,
		.in_mem_op_i, .in_mem_addr_i, .in_ri_i, .in_sys_i, .in_bp_i, .in_ov_i,
		.in_trap_i, .in_eret_i,
		.commit_i(redir_free),
		.rec_valid_o(rec_valid), .rec_pc_o(rec_pc), .rec_delay_slot_o(rec_delay_slot),
		.rec_bad_addr_o(rec_bad_addr), .rec_adel_o(rec_adel), .rec_ades_o(rec_ades),
		.rec_ri_o(rec_ri), .rec_sys_o(rec_sys), .rec_bp_o(rec_bp), .rec_ov_o(rec_ov),
		.rec_trap_o(rec_trap), .rec_eret_o(rec_eret)
	);

	exc_prioritize i_exc_prioritize (
		.rec_valid_i(rec_valid), .rec_adel_i(rec_adel), .rec_ades_i(rec_ades),
		.rec_ri_i(rec_ri), .rec_sys_i(rec_sys), .rec_bp_i(rec_bp), .rec_ov_i(rec_ov),
		.rec_trap_i(rec_trap), .rec_eret_i(rec_eret),
		.status_i(status), .cause_i(cause),
		.exc_taken_o(exc_taken), .exc_code_o(exc_code), .exc_eret_o(exc_eret)
	);

	cp0_regs i_cp0_regs (
		.clk, .rst_n_i, .int_i,
		.cp0_we_i, .cp0_waddr_i, .cp0_wsel_i, .cp0_wdata_i,
		.cp0_raddr_i, .cp0_rsel_i, .cp0_rdata_o,
		.commit_i(redir_free), .exc_taken_i(exc_taken), .exc_code_i(exc_code),
		.exc_eret_i(exc_eret), .rec_pc_i(rec_pc), .rec_delay_slot_i(rec_delay_slot),
		.rec_bad_addr_i(rec_bad_addr),
		.status_o(status), .cause_o(cause), .epc_o(epc), .ebase_o(ebase)
	);

	redirect_gen i_redirect_gen (
		.clk, .rst_n_i,
		.commit_i(redir_free), .exc_taken_i(exc_taken), .exc_code_i(exc_code),
		.exc_eret_i(exc_eret), .epc_i(epc), .ebase_i(ebase), .status_i(status),
		.redir_free_o(redir_free),
		.redirect_valid_o, .redirect_ready_i, .redirect_pc_o, .redirect_code_o,
		.redirect_eret_o
	);

endmodule

// ==== src/redirect_gen.sv ====
`timescale 1ns/1ps

module redirect_gen (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  commit_i,
	input  logic                  exc_taken_i,
	input  exc_pkg::exc_code_e    exc_code_i,
	input  logic                  exc_eret_i,
	input  logic [31:0]           epc_i,
	input  logic [31:0]           ebase_i,
	input  logic [31:0]           status_i,
	output logic                  redir_free_o,
	output logic                  redirect_valid_o,
	input  logic                  redirect_ready_i,
	output logic [31:0]           redirect_pc_o,
	output exc_pkg::exc_code_e    redirect_code_o,
	output logic                  redirect_eret_o
);

	logic        load;
	logic [31:0] target;

	assign redir_free_o = ~redirect_valid_o | redirect_ready_i;
	assign load         = commit_i & (exc_taken_i | exc_eret_i);

	// CP0 values before this commit lands
	assign target = exc_eret_i ? epc_i :
		status_i[cp0_pkg::status_bev_bit] ? exc_pkg::boot_vector :
		ebase_i + exc_pkg::vec_offset;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			redirect_valid_o <= 1'b0;
		end else if (load) begin
			redirect_valid_o <= 1'b1;
		end else if (redirect_ready_i) begin
			redirect_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			redirect_pc_o   <= target;
			redirect_code_o <= exc_code_i;
			redirect_eret_o <= exc_eret_i;
		end
	end

endmodule
